// File: common/comms_config.svh
/* Widths, frame layout, identity words and timeouts of the comms link.
   Included by the package and by every block that needs these values. */
`ifndef COMMS_CONFIG_SVH
`define COMMS_CONFIG_SVH

// Local bus
`define COMMS_LB_AWI        24
`define COMMS_LB_DWI        32
`define COMMS_LOCAL_AWI     4

// Lane and frame
`define COMMS_WORD_W        16
`define COMMS_SOF_WORD      16'hbc50
`define COMMS_IDLE_WORD     16'hbc1c
`define COMMS_FRAME_LEN     9

// Values this end puts in its header
`define COMMS_PROTOCOL_VER  4'h2
`define COMMS_GATEWARE_TYPE 3'h5
`define COMMS_REV_ID        32'h1b3d_0001

// Read-only identity and unmapped read value
`define COMMS_INFO0         "QF2P"
`define COMMS_INFO1         "COMM"
`define COMMS_BAD_ADDR      32'hdeadf00d

// Cycles without a start word before loss of signal
`define COMMS_LOS_TIMEOUT   64

`endif

// File: common/comms_pkg.sv
/* Shared types of the comms link: lane and bus words, counters, fault bits
   and the receive state machine encoding. */
`include "comms_config.svh"

package comms_pkg;

   // One word on the transmit or receive lane
   typedef logic [`COMMS_WORD_W-1:0] lane_word_t;

   // Local bus data and address
   typedef logic [`COMMS_LB_DWI-1:0] lb_data_t;
   typedef logic [`COMMS_LB_AWI-1:0] lb_addr_t;

   // Frame, fault and latency counters
   typedef logic [15:0] count_t;

   // Board location carried in the header
   typedef logic [2:0] location_t;

   // Fault bits
   // bit 0 checksum error
   // bit 1 K word inside a frame body
   // bit 2 protocol version mismatch
   typedef logic [2:0] fault_t;

   // Receive deframer states
   typedef enum logic [1:0] {
      RX_HUNT  = 2'd0,
      RX_BODY  = 2'd1,
      RX_CHECK = 2'd2
   } rx_state_t;

endpackage

// File: regbank/comms_top_regbank.sv
/* Local-bus register bank of the comms link. Decodes the low address bits,
   holds the transmit controls and returns link status on a registered read. */
`timescale 1ns/1ps
`include "comms_config.svh"

module comms_top_regbank (
   input  logic                  lb_clk,
   input  logic                  reset_i,

   // Local bus
   input  logic                  lb_valid_i,
   input  logic                  lb_rnw_i,
   input  comms_pkg::lb_addr_t   lb_addr_i,
   input  comms_pkg::lb_data_t   lb_wdata_i,
   output comms_pkg::lb_data_t   lb_rdata_o,

   // Status from the receive deframer
   input  comms_pkg::count_t     rx_frame_counter_i,
   input  comms_pkg::count_t     txrx_latency_i,
   input  comms_pkg::fault_t     ccrx_fault_i,
   input  comms_pkg::count_t     ccrx_fault_cnt_i,
   input  logic                  ccrx_los_i,
   input  logic [3:0]            rx_protocol_ver_i,
   input  logic [2:0]            rx_gateware_type_i,
   input  comms_pkg::location_t  rx_location_i,
   input  comms_pkg::lb_data_t   rx_rev_id_i,
   input  comms_pkg::lb_data_t   rx_data0_i,
   input  comms_pkg::lb_data_t   rx_data1_i,

   // Controls to the transmit framer
   output comms_pkg::location_t  tx_location_o,
   output logic                  tx_transmit_en_o
);

   localparam int AWI = `COMMS_LOCAL_AWI;

   // Read map
   localparam logic [AWI-1:0] INFO0_RD            = 4'd0;
   localparam logic [AWI-1:0] INFO1_RD            = 4'd1;
   localparam logic [AWI-1:0] RX_FRAME_COUNTER_RD = 4'd2;
   localparam logic [AWI-1:0] TXRX_LATENCY_RD     = 4'd3;
   localparam logic [AWI-1:0] CCRX_FAULT_RD       = 4'd4;
   localparam logic [AWI-1:0] CCRX_FAULT_CNT_RD   = 4'd5;
   localparam logic [AWI-1:0] CCRX_LOS_RD         = 4'd6;
   localparam logic [AWI-1:0] RX_PROTOCOL_VER_RD  = 4'd7;
   localparam logic [AWI-1:0] RX_GATEWARE_TYPE_RD = 4'd8;
   localparam logic [AWI-1:0] RX_LOCATION_RD      = 4'd9;
   localparam logic [AWI-1:0] RX_REV_ID_RD        = 4'd10;
   localparam logic [AWI-1:0] RX_DATA0_RD         = 4'd11;
   localparam logic [AWI-1:0] RX_DATA1_RD         = 4'd12;

   // Write map
   localparam logic [AWI-1:0] TX_LOCATION_WR      = 4'd0;
   localparam logic [AWI-1:0] TX_TRANSMIT_EN_WR   = 4'd1;

   logic [AWI-1:0] local_addr;

   assign local_addr = lb_addr_i[AWI-1:0];

   // ----------------------------------------
   // Read path
   // ----------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         lb_rdata_o <= '0;
      end else if (lb_valid_i && lb_rnw_i) begin
         case (local_addr)
            INFO0_RD:            lb_rdata_o <= `COMMS_INFO0;
            INFO1_RD:            lb_rdata_o <= `COMMS_INFO1;
            RX_FRAME_COUNTER_RD: lb_rdata_o <= comms_pkg::lb_data_t'(rx_frame_counter_i);
            TXRX_LATENCY_RD:     lb_rdata_o <= comms_pkg::lb_data_t'(txrx_latency_i);
            CCRX_FAULT_RD:       lb_rdata_o <= comms_pkg::lb_data_t'(ccrx_fault_i);
            CCRX_FAULT_CNT_RD:   lb_rdata_o <= comms_pkg::lb_data_t'(ccrx_fault_cnt_i);
            CCRX_LOS_RD:         lb_rdata_o <= comms_pkg::lb_data_t'(ccrx_los_i);
            RX_PROTOCOL_VER_RD:  lb_rdata_o <= comms_pkg::lb_data_t'(rx_protocol_ver_i);
            RX_GATEWARE_TYPE_RD: lb_rdata_o <= comms_pkg::lb_data_t'(rx_gateware_type_i);
            RX_LOCATION_RD:      lb_rdata_o <= comms_pkg::lb_data_t'(rx_location_i);
            RX_REV_ID_RD:        lb_rdata_o <= rx_rev_id_i;
            RX_DATA0_RD:         lb_rdata_o <= rx_data0_i;
            RX_DATA1_RD:         lb_rdata_o <= rx_data1_i;
            default:             lb_rdata_o <= `COMMS_BAD_ADDR;
         endcase
      end
   end

   // ----------------------------------------
   // Write path
   // ----------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         tx_location_o    <= '0;
         tx_transmit_en_o <= 1'b0;
      end else if (lb_valid_i && !lb_rnw_i) begin
         case (local_addr)
            TX_LOCATION_WR:    tx_location_o    <= lb_wdata_i[2:0];
            TX_TRANSMIT_EN_WR: tx_transmit_en_o <= lb_wdata_i[0];
            // Other addresses have no write register
            default: ;
         endcase
      end
   end

endmodule

// File: link/comms_tx_framer.sv
/* Transmit framer. Sends the 9-word status frame back to back while transmit
   is enabled and idle K words otherwise; pulses tx_sof_o with each start word. */
`timescale 1ns/1ps
`include "comms_config.svh"

module comms_tx_framer (
   input  logic                  lb_clk,
   input  logic                  reset_i,
   input  logic                  transmit_en_i,
   input  comms_pkg::location_t  location_i,
   input  comms_pkg::lb_data_t   data0_i,
   input  comms_pkg::lb_data_t   data1_i,
   output comms_pkg::lane_word_t tx_word_o,
   output logic                  tx_is_k_o,
   output logic                  tx_sof_o
);

   localparam logic [3:0] LAST_IDX = 4'(`COMMS_FRAME_LEN - 1);
   localparam logic [3:0] SUM_IDX  = LAST_IDX - 4'd1;
   localparam logic [31:0] REV_ID  = `COMMS_REV_ID;

   // Index of the word now on tx_word_o, LAST_IDX also when idle
   logic [3:0]            word_idx;
   logic                  frame_start;
   comms_pkg::lane_word_t next_word;
   comms_pkg::lane_word_t sum;

   // Frame content latched at each start word
   comms_pkg::location_t  loc_q;
   comms_pkg::lb_data_t   data0_q;
   comms_pkg::lb_data_t   data1_q;

   assign frame_start = (word_idx == LAST_IDX) && transmit_en_i;

   // Word that follows the one at word_idx
   always_comb begin
      case (word_idx)
         4'd0:    next_word = {6'd0, `COMMS_PROTOCOL_VER, `COMMS_GATEWARE_TYPE, loc_q};
         4'd1:    next_word = REV_ID[31:16];
         4'd2:    next_word = REV_ID[15:0];
         4'd3:    next_word = data0_q[31:16];
         4'd4:    next_word = data0_q[15:0];
         4'd5:    next_word = data1_q[31:16];
         4'd6:    next_word = data1_q[15:0];
         default: next_word = sum;
      endcase
   end

   always_ff @(posedge lb_clk) begin
      if (frame_start) begin
         loc_q   <= location_i;
         data0_q <= data0_i;
         data1_q <= data1_i;
      end
   end

   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         word_idx  <= LAST_IDX;
         tx_word_o <= `COMMS_IDLE_WORD;
         tx_is_k_o <= 1'b1;
         tx_sof_o  <= 1'b0;
         sum       <= '0;
      end else begin
         tx_sof_o <= frame_start;
         if (word_idx != LAST_IDX) begin
            word_idx  <= word_idx + 4'd1;
            tx_word_o <= next_word;
            tx_is_k_o <= 1'b0;
            // Checksum covers header to last payload word
            if (word_idx != SUM_IDX)
               sum <= sum + next_word;
         end else if (frame_start) begin
            word_idx  <= 4'd0;
            tx_word_o <= `COMMS_SOF_WORD;
            tx_is_k_o <= 1'b1;
            sum       <= '0;
         end else begin
            tx_word_o <= `COMMS_IDLE_WORD;
            tx_is_k_o <= 1'b1;
         end
      end
   end

endmodule

// File: link/comms_rx_deframer.sv
/* Receive deframer. Locks to start words, checks each frame and commits good
   ones to the status outputs; also tracks faults, loss of signal and latency. */
`timescale 1ns/1ps
`include "comms_config.svh"

module comms_rx_deframer (
   input  logic                  lb_clk,
   input  logic                  reset_i,
   input  comms_pkg::lane_word_t rx_word_i,
   input  logic                  rx_is_k_i,
   input  logic                  tx_sof_i,
   output comms_pkg::count_t     frame_counter_o,
   output comms_pkg::count_t     latency_o,
   output comms_pkg::count_t     fault_cnt_o,
   output comms_pkg::fault_t     fault_o,
   output logic                  los_o,
   output logic [3:0]            protocol_ver_o,
   output logic [2:0]            gateware_type_o,
   output comms_pkg::location_t  location_o,
   output comms_pkg::lb_data_t   rev_id_o,
   output comms_pkg::lb_data_t   data0_o,
   output comms_pkg::lb_data_t   data1_o
);

   // Body is everything between start word and checksum
   localparam int         BODY_WORDS = `COMMS_FRAME_LEN - 2;
   localparam logic [2:0] BODY_LAST  = 3'(BODY_WORDS - 1);
   localparam comms_pkg::count_t LOS_LIMIT = 16'(`COMMS_LOS_TIMEOUT);

   comms_pkg::rx_state_t  state;
   logic [2:0]            body_idx;
   comms_pkg::lane_word_t sum;
   comms_pkg::lane_word_t shadow [BODY_WORDS];
   logic                  rx_sof;
   comms_pkg::fault_t     check_faults;
   comms_pkg::count_t     cyc_cnt;
   comms_pkg::count_t     los_cnt;

   assign rx_sof = rx_is_k_i && (rx_word_i == `COMMS_SOF_WORD);

   // Faults seen while the checksum word is on the lane
   assign check_faults = {shadow[0][9:6] != `COMMS_PROTOCOL_VER,
                          rx_is_k_i,
                          rx_word_i != sum};

   always_ff @(posedge lb_clk) begin
      if (state == comms_pkg::RX_BODY && !rx_is_k_i)
         shadow[body_idx] <= rx_word_i;
   end

   // ----------------------------------------
   // Frame state machine
   // ----------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         state           <= comms_pkg::RX_HUNT;
         body_idx        <= '0;
         sum             <= '0;
         frame_counter_o <= '0;
         fault_cnt_o     <= '0;
         fault_o         <= '0;
         protocol_ver_o  <= '0;
         gateware_type_o <= '0;
         location_o      <= '0;
         rev_id_o        <= '0;
         data0_o         <= '0;
         data1_o         <= '0;
      end else begin
         case (state)
            comms_pkg::RX_HUNT: begin
               body_idx <= '0;
               sum      <= '0;
               if (rx_sof)
                  state <= comms_pkg::RX_BODY;
            end
            comms_pkg::RX_BODY: begin
               if (rx_is_k_i) begin
                  // Broken frame, resync at once if this was a new start
                  fault_o     <= 3'b010;
                  fault_cnt_o <= fault_cnt_o + 16'd1;
                  body_idx    <= '0;
                  sum         <= '0;
                  state       <= rx_sof ? comms_pkg::RX_BODY : comms_pkg::RX_HUNT;
               end else begin
                  sum      <= sum + rx_word_i;
                  body_idx <= body_idx + 3'd1;
                  if (body_idx == BODY_LAST)
                     state <= comms_pkg::RX_CHECK;
               end
            end
            comms_pkg::RX_CHECK: begin
               body_idx <= '0;
               sum      <= '0;
               state    <= rx_sof ? comms_pkg::RX_BODY : comms_pkg::RX_HUNT;
               if (check_faults == '0) begin
                  frame_counter_o <= frame_counter_o + 16'd1;
                  protocol_ver_o  <= shadow[0][9:6];
                  gateware_type_o <= shadow[0][5:3];
                  location_o      <= shadow[0][2:0];
                  rev_id_o        <= {shadow[1], shadow[2]};
                  data0_o         <= {shadow[3], shadow[4]};
                  data1_o         <= {shadow[5], shadow[6]};
               end else begin
                  // Fault bits describe the most recent bad frame
                  fault_o     <= check_faults;
                  fault_cnt_o <= fault_cnt_o + 16'd1;
               end
            end
            default: state <= comms_pkg::RX_HUNT;
         endcase
      end
   end

   // ----------------------------------------
   // Latency and loss of signal
   // ----------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         cyc_cnt   <= '0;
         latency_o <= '0;
         los_cnt   <= '0;
         los_o     <= 1'b0;
      end else begin
         // Counts edges since the local start word left
         cyc_cnt <= tx_sof_i ? 16'd1 : cyc_cnt + 16'd1;
         if (rx_sof) begin
            latency_o <= cyc_cnt;
            los_cnt   <= '0;
            los_o     <= 1'b0;
         end else if (los_cnt != LOS_LIMIT - 16'd1) begin
            los_cnt <= los_cnt + 16'd1;
         end else begin
            los_o <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/comms_top.sv
/* Top level of the comms link controller. Joins the transmit framer, the
   receive deframer and the local-bus register bank. */
`timescale 1ns/1ps

module comms_top (
   input  logic                  lb_clk,
   input  logic                  reset_i,

   // Local bus
   input  logic                  lb_valid_i,
   input  logic                  lb_rnw_i,
   input  comms_pkg::lb_addr_t   lb_addr_i,
   input  comms_pkg::lb_data_t   lb_wdata_i,
   output comms_pkg::lb_data_t   lb_rdata_o,

   // Payload sampled at each frame start
   input  comms_pkg::lb_data_t   tx_data0_i,
   input  comms_pkg::lb_data_t   tx_data1_i,

   // Lanes
   output comms_pkg::lane_word_t tx_word_o,
   output logic                  tx_is_k_o,
   input  comms_pkg::lane_word_t rx_word_i,
   input  logic                  rx_is_k_i
);

   comms_pkg::location_t tx_location;
   logic                 tx_transmit_en;
   logic                 tx_sof;

   comms_pkg::count_t    rx_frame_counter;
   comms_pkg::count_t    txrx_latency;
   comms_pkg::count_t    ccrx_fault_cnt;
   comms_pkg::fault_t    ccrx_fault;
   logic                 ccrx_los;
   logic [3:0]           rx_protocol_ver;
   logic [2:0]           rx_gateware_type;
   comms_pkg::location_t rx_location;
   comms_pkg::lb_data_t  rx_rev_id;
   comms_pkg::lb_data_t  rx_data0;
   comms_pkg::lb_data_t  rx_data1;

   comms_tx_framer i_tx_framer (
      .lb_clk        (lb_clk),
      .reset_i       (reset_i),
      .transmit_en_i (tx_transmit_en),
      .location_i    (tx_location),
      .data0_i       (tx_data0_i),
      .data1_i       (tx_data1_i),
      .tx_word_o     (tx_word_o),
      .tx_is_k_o     (tx_is_k_o),
      .tx_sof_o      (tx_sof)
   );

   comms_rx_deframer i_rx_deframer (
      .lb_clk          (lb_clk),
      .reset_i         (reset_i),
      .rx_word_i       (rx_word_i),
      .rx_is_k_i       (rx_is_k_i),
      .tx_sof_i        (tx_sof),
      .frame_counter_o (rx_frame_counter),
      .latency_o       (txrx_latency),
      .fault_cnt_o     (ccrx_fault_cnt),
      .fault_o         (ccrx_fault),
      .los_o           (ccrx_los),
      .protocol_ver_o  (rx_protocol_ver),
      .gateware_type_o (rx_gateware_type),
      .location_o      (rx_location),
      .rev_id_o        (rx_rev_id),
      .data0_o         (rx_data0),
      .data1_o         (rx_data1)
   );

   comms_top_regbank i_regbank (
      .lb_clk             (lb_clk),
      .reset_i            (reset_i),
      .lb_valid_i         (lb_valid_i),
      .lb_rnw_i           (lb_rnw_i),
      .lb_addr_i          (lb_addr_i),
      .lb_wdata_i         (lb_wdata_i),
      .lb_rdata_o         (lb_rdata_o),
      .rx_frame_counter_i (rx_frame_counter),
      .txrx_latency_i     (txrx_latency),
      .ccrx_fault_i       (ccrx_fault),
      .ccrx_fault_cnt_i   (ccrx_fault_cnt),
      .ccrx_los_i         (ccrx_los),
      .rx_protocol_ver_i  (rx_protocol_ver),
      .rx_gateware_type_i (rx_gateware_type),
      .rx_location_i      (rx_location),
      .rx_rev_id_i        (rx_rev_id),
      .rx_data0_i         (rx_data0),
      .rx_data1_i         (rx_data1),
      .tx_location_o      (tx_location),
      .tx_transmit_en_o   (tx_transmit_en)
   );

endmodule

// File: testbench/comms_clk_gen.sv
/* Testbench clock source. Drives lb_clk with a 40 ns period from time zero. */
`timescale 1ns/1ps

module comms_clk_gen (
   output logic lb_clk
);

   localparam int HALF_PERIOD = 20;

   initial begin
      lb_clk = 1'b0;
      forever #HALF_PERIOD lb_clk = ~lb_clk;
   end

endmodule

// File: testbench/comms_props.sv
/* Protocol assertions for the comms link top level, attached with bind.
   Covers K words on the transmit lane, idle while disabled and read data. */
`timescale 1ns/1ps
`include "comms_config.svh"

module comms_props (
   input logic                  lb_clk,
   input logic                  reset_i,
   input logic                  lb_valid_i,
   input logic                  lb_rnw_i,
   input comms_pkg::lb_data_t   lb_rdata_i,
   input comms_pkg::lane_word_t tx_word_i,
   input logic                  tx_is_k_i,
   input logic                  tx_transmit_en_i
);

   // Only two K words exist on the lane
   k_word_known: assert property (@(posedge lb_clk) disable iff (reset_i)
      tx_is_k_i |-> (tx_word_i == `COMMS_SOF_WORD || tx_word_i == `COMMS_IDLE_WORD))
      else $error("K word on the transmit lane is neither start nor idle");

   // An idle framer with enable low stays idle
   idle_while_disabled: assert property (@(posedge lb_clk) disable iff (reset_i)
      (!tx_transmit_en_i && tx_is_k_i && tx_word_i == `COMMS_IDLE_WORD)
      |=> (tx_is_k_i && tx_word_i == `COMMS_IDLE_WORD))
      else $error("Transmit lane left idle while transmit was disabled");

   // Read data only moves on a read strobe
   rdata_holds: assert property (@(posedge lb_clk) disable iff (reset_i)
      !(lb_valid_i && lb_rnw_i) |=> $stable(lb_rdata_i))
      else $error("Read data changed without a read strobe");

endmodule

bind comms_top comms_props i_props (
   .lb_clk           (lb_clk),
   .reset_i          (reset_i),
   .lb_valid_i       (lb_valid_i),
   .lb_rnw_i         (lb_rnw_i),
   .lb_rdata_i       (lb_rdata_o),
   .tx_word_i        (tx_word_o),
   .tx_is_k_i        (tx_is_k_o),
   .tx_transmit_en_i (tx_transmit_en)
);

// File: testbench/comms_tb.sv
/* Testbench for the comms link top level. Loops the transmit lane back through
   a delay line with error injection and checks the register bank read-back. */
`timescale 1ns/1ps
`include "comms_config.svh"

module comms_tb;

   localparam int DELAY       = 3;
   localparam int READ_LIMIT  = 100;
   localparam int CYCLE_LIMIT = 100;
   localparam int FRAME_LEN   = `COMMS_FRAME_LEN;

   logic                  lb_clk;
   logic                  reset_i = 1'b1;
   logic                  lb_valid_i = 1'b0;
   logic                  lb_rnw_i = 1'b1;
   comms_pkg::lb_addr_t   lb_addr_i = '0;
   comms_pkg::lb_data_t   lb_wdata_i = '0;
   comms_pkg::lb_data_t   lb_rdata_o;
   comms_pkg::lb_data_t   tx_data0_i = '0;
   comms_pkg::lb_data_t   tx_data1_i = '0;
   comms_pkg::lane_word_t tx_word_o;
   logic                  tx_is_k_o;
   comms_pkg::lane_word_t rx_word_i = `COMMS_IDLE_WORD;
   logic                  rx_is_k_i = 1'b1;

   // Loopback line of {is_k, word} entries
   logic [16:0] delay_q [DELAY] = '{default: {1'b1, `COMMS_IDLE_WORD}};
   int          out_pos = 15;
   int          corrupt_req = 0;
   int          corrupt_done = 0;
   logic        force_idle = 1'b0;
   int          seed = 32'hb19e_8f0b;

   comms_clk_gen i_clk_gen (
      .lb_clk (lb_clk)
   );

   comms_top i_dut (
      .lb_clk     (lb_clk),
      .reset_i    (reset_i),
      .lb_valid_i (lb_valid_i),
      .lb_rnw_i   (lb_rnw_i),
      .lb_addr_i  (lb_addr_i),
      .lb_wdata_i (lb_wdata_i),
      .lb_rdata_o (lb_rdata_o),
      .tx_data0_i (tx_data0_i),
      .tx_data1_i (tx_data1_i),
      .tx_word_o  (tx_word_o),
      .tx_is_k_o  (tx_is_k_o),
      .rx_word_i  (rx_word_i),
      .rx_is_k_i  (rx_is_k_i)
   );

   // ----------------------------------------
   // Loopback with error injection
   // ----------------------------------------
   // out_pos is the frame position of the word last driven to the receiver
   always @(negedge lb_clk) begin
      for (int i = DELAY - 1; i > 0; i--) begin
         delay_q[i] <= delay_q[i-1];
      end
      delay_q[0] <= {tx_is_k_o, tx_word_o};
      if (delay_q[DELAY-1][16] && delay_q[DELAY-1][15:0] == `COMMS_SOF_WORD)
         out_pos <= 0;
      else if (out_pos < 15)
         out_pos <= out_pos + 1;
      if (force_idle) begin
         rx_is_k_i <= 1'b1;
         rx_word_i <= `COMMS_IDLE_WORD;
      end else if (corrupt_req != corrupt_done && !delay_q[DELAY-1][16] && out_pos == 3) begin
         // Flip a bit in the upper half of the first payload word
         rx_is_k_i    <= 1'b0;
         rx_word_i    <= delay_q[DELAY-1][15:0] ^ 16'h0001;
         corrupt_done <= corrupt_done + 1;
      end else begin
         rx_is_k_i <= delay_q[DELAY-1][16];
         rx_word_i <= delay_q[DELAY-1][15:0];
      end
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_equal(input string name, input comms_pkg::lb_data_t got,
                              input comms_pkg::lb_data_t exp);
      assert (got == exp) else begin
         abort_run($sformatf("Mismatch at time %0t: %s read %h, expected %h",
                             $time, name, got, exp));
      end
   endtask

   // Starts on a falling edge and returns on the next one
   task automatic read_reg(input int addr, output comms_pkg::lb_data_t data);
      lb_valid_i = 1'b1;
      lb_rnw_i   = 1'b1;
      lb_addr_i  = comms_pkg::lb_addr_t'(addr);
      @(negedge lb_clk);
      lb_valid_i = 1'b0;
      data = lb_rdata_o;
   endtask

   task automatic write_reg(input int addr, input comms_pkg::lb_data_t data);
      lb_valid_i = 1'b1;
      lb_rnw_i   = 1'b0;
      lb_addr_i  = comms_pkg::lb_addr_t'(addr);
      lb_wdata_i = data;
      @(negedge lb_clk);
      lb_valid_i = 1'b0;
      lb_rnw_i   = 1'b1;
   endtask

   // Returns on the first later falling edge with a start word on the transmit lane
   task automatic wait_tx_sof();
      int tries;
      tries = 0;
      @(negedge lb_clk);
      while (!(tx_is_k_o && tx_word_o == `COMMS_SOF_WORD)) begin
         if (tries == CYCLE_LIMIT)
            abort_run("Timeout while waiting for a start word on the transmit lane");
         tries++;
         @(negedge lb_clk);
      end
   endtask

   task automatic wait_reg_change(input int addr, input comms_pkg::lb_data_t old,
                                  input string name, output comms_pkg::lb_data_t val);
      int tries;
      tries = 0;
      read_reg(addr, val);
      while (val == old) begin
         if (tries == READ_LIMIT)
            abort_run($sformatf("Timeout while waiting for %s to change", name));
         tries++;
         read_reg(addr, val);
      end
   endtask

   task automatic wait_reg_equal(input int addr, input comms_pkg::lb_data_t want,
                                 input string name);
      int tries;
      comms_pkg::lb_data_t val;
      tries = 0;
      read_reg(addr, val);
      while (val != want) begin
         if (tries == READ_LIMIT)
            abort_run($sformatf("Timeout while waiting for %s to reach %h", name, want));
         tries++;
         read_reg(addr, val);
      end
   endtask

   task automatic expect_reg(input int addr, input comms_pkg::lb_data_t exp,
                             input string name);
      comms_pkg::lb_data_t val;
      read_reg(addr, val);
      check_equal(name, val, exp);
   endtask

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      int                  tries;
      comms_pkg::lb_data_t rd;
      comms_pkg::lb_data_t prev;
      comms_pkg::lb_data_t exp_data0;
      comms_pkg::lb_data_t exp_data1;
      comms_pkg::lb_data_t new_data0;
      comms_pkg::lb_data_t new_data1;

      exp_data0  = $random(seed);
      exp_data1  = $random(seed);
      tx_data0_i = exp_data0;
      tx_data1_i = exp_data1;
      repeat (16) @(negedge lb_clk);
      reset_i = 1'b0;

      // Identity words, unmapped read, idle lane
      expect_reg(0, `COMMS_INFO0, "INFO0");
      expect_reg(1, `COMMS_INFO1, "INFO1");
      expect_reg(13, `COMMS_BAD_ADDR, "unmapped address 13");
      repeat (2 * FRAME_LEN) begin
         @(negedge lb_clk);
         check_equal("tx_is_k_o", comms_pkg::lb_data_t'(tx_is_k_o), 32'd1);
         check_equal("tx_word_o", comms_pkg::lb_data_t'(tx_word_o),
                     comms_pkg::lb_data_t'(`COMMS_IDLE_WORD));
      end

      // Link up and received fields
      write_reg(0, 32'd5);
      write_reg(1, 32'd1);
      wait_reg_change(2, 32'd0, "rx_frame_counter", rd);
      expect_reg(9, 32'd5, "rx_location");
      expect_reg(7, comms_pkg::lb_data_t'(`COMMS_PROTOCOL_VER), "rx_protocol_ver");
      expect_reg(8, comms_pkg::lb_data_t'(`COMMS_GATEWARE_TYPE), "rx_gateware_type");
      expect_reg(10, `COMMS_REV_ID, "rx_rev_id");
      expect_reg(11, exp_data0, "rx_data0");
      expect_reg(12, exp_data1, "rx_data1");
      expect_reg(3, comms_pkg::lb_data_t'(DELAY), "txrx_latency");

      // One corrupted payload word in the first frame with a new payload
      read_reg(5, prev);
      new_data0  = $random(seed);
      new_data1  = $random(seed);
      tx_data0_i = new_data0;
      tx_data1_i = new_data1;
      wait_tx_sof();
      corrupt_req <= corrupt_req + 1;
      wait_reg_change(5, prev, "ccrx_fault_cnt", rd);
      check_equal("ccrx_fault_cnt", rd, prev + 32'd1);
      expect_reg(4, 32'd1, "ccrx_fault");
      expect_reg(11, exp_data0, "rx_data0");
      expect_reg(12, exp_data1, "rx_data1");
      read_reg(2, prev);
      wait_reg_change(2, prev, "rx_frame_counter", rd);
      check_equal("rx_frame_counter", rd, prev + 32'd1);
      expect_reg(11, new_data0, "rx_data0");
      expect_reg(12, new_data1, "rx_data1");

      // Loss of signal and recovery
      force_idle <= 1'b1;
      wait_reg_equal(6, 32'd1, "ccrx_los");
      force_idle <= 1'b0;
      read_reg(2, prev);
      wait_reg_change(2, prev, "rx_frame_counter", rd);
      expect_reg(6, 32'd0, "ccrx_los");

      // Transmit off and the frame counter freezes
      write_reg(1, 32'd0);
      tries = 0;
      while (!(tx_is_k_o && tx_word_o == `COMMS_IDLE_WORD)) begin
         if (tries == CYCLE_LIMIT)
            abort_run("Timeout while waiting for the transmit lane to go idle");
         tries++;
         @(negedge lb_clk);
      end
      repeat (FRAME_LEN) @(negedge lb_clk);
      read_reg(2, prev);
      repeat (2 * FRAME_LEN) @(negedge lb_clk);
      expect_reg(2, prev, "rx_frame_counter");

      $display("Test OK");
      $finish;
   end

endmodule

// File: build.f
+incdir+common
common/comms_pkg.sv
regbank/comms_top_regbank.sv
link/comms_tx_framer.sv
link/comms_rx_deframer.sv
verilog/comms_top.sv
testbench/comms_clk_gen.sv
testbench/comms_props.sv
testbench/comms_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the comms link testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module comms_tb -f build.f -o comms_sim \
   || { echo "Build failed"; exit 1; }
out="$(./obj_dir/comms_sim)"
echo "$out"
echo "$out" | grep -q "Test OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
